/* hdl/cdp_pkg.sv */
/*
 * Shared types for the cross-channel normalization datapath.
 * LANES channel values per beat, each a signed 8-bit value.
 * Window sums are 18 bits wide, enough for nine squares of -128.
 * cfg_t must be held stable while beats are in flight.
 */
`default_nettype none

package cdp_pkg;

  localparam int LANES = 8;  // channel values per beat

  // one pixel beat, lane i in bits [8*i +: 8]
  typedef logic [LANES-1:0][7:0]  lane_vec_t;
  typedef logic [LANES-1:0][17:0] sum_vec_t;   // unsigned window sums
  typedef logic [LANES-1:0][15:0] fac_vec_t;   // unsigned table factors

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic signed [15:0] datin_offset;      // subtracted before scale
    logic signed [15:0] datin_scale;
    logic        [4:0]  datin_shifter;     // arithmetic right shift
    logic        [1:0]  normalz_len;       // 0..3 -> window 3,5,7,9
    logic        [4:0]  lut_index_select;  // right shift of the sum
    logic               mul_bypass;
    logic        [5:0]  datout_shifter;
  } cfg_t;

  // clip a wide signed value into the int8 range
  function automatic logic [7:0] sat_s8(input logic signed [39:0] v);
    if (v > 40'sd127) begin
      return 8'h7f;
    end else if (v < -40'sd128) begin
      return 8'h80;
    end else begin
      return v[7:0];
    end
  endfunction

endpackage

`default_nettype wire

/* hdl/cdp_cvt_in.sv */
/*
 * Input conversion stage, one output register.
 * Per lane ((x - offset) * scale) >>> shifter, saturated to int8.
 * The register forks to the square-sum and the sync FIFO and is freed
 * only when both take the beat in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_cvt_in (
  input  wire logic              nvdla_core_clk,
  input  wire logic              nvdla_core_rstn,
  input  wire cdp_pkg::cfg_t     cfg,
  input  wire logic              in_valid,
  output logic                   in_ready,
  input  wire cdp_pkg::lane_vec_t in_data,
  output logic                   cvt2sum_valid,
  input  wire logic              cvt2sum_ready,
  output logic                   cvt2sync_valid,
  input  wire logic              cvt2sync_ready,
  output cdp_pkg::lane_vec_t     cvt_data
);

  logic               cvt_vld;   // output register holds a beat
  logic               both_rdy;  // both fork sides can take it
  cdp_pkg::lane_vec_t cvt_next;

  ////////////////////////////////////////////////////////////
  // per lane conversion
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < cdp_pkg::LANES; i++) begin : g_lane
    logic signed [16:0] diff;   // int8 minus int16
    logic signed [32:0] prod;
    logic signed [39:0] shf;

    assign diff = $signed(in_data[i]) - $signed(cfg.datin_offset);
    assign prod = diff * $signed(cfg.datin_scale);
    assign shf  = prod >>> cfg.datin_shifter;   // sign fills from the top
    assign cvt_next[i] = cdp_pkg::sat_s8(shf);
  end

  // fork, each side sees valid only if the other is ready too
  assign both_rdy       = cvt2sum_ready & cvt2sync_ready;
  assign cvt2sum_valid  = cvt_vld & cvt2sync_ready;
  assign cvt2sync_valid = cvt_vld & cvt2sum_ready;
  assign in_ready       = ~cvt_vld | both_rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cvt_vld <= 1'b0;
    end else if (in_ready) begin
      cvt_vld <= in_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid && in_ready) begin
      cvt_data <= cvt_next;  // payload, no reset
    end
  end

  // a stalled beat must not change under either consumer
  a_cvt_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cvt_vld && !both_rdy |=> cvt_vld && $stable(cvt_data));

endmodule

`default_nettype wire

/* hdl/cdp_sqsum.sv */
/*
 * Windowed sum of squares over neighbouring lanes, one output register.
 * Radius is normalz_len + 1, lanes outside the beat count as zero.
 * No wrap between beats, each beat is summed on its own.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_sqsum (
  input  wire logic               nvdla_core_clk,
  input  wire logic               nvdla_core_rstn,
  input  wire logic [1:0]         normalz_len,
  input  wire logic               cvt2sum_valid,
  output logic                    cvt2sum_ready,
  input  wire cdp_pkg::lane_vec_t cvt_data,
  output logic                    sum2lut_valid,
  input  wire logic               sum2lut_ready,
  output cdp_pkg::sum_vec_t       sum2lut_data
);

  logic [cdp_pkg::LANES-1:0][14:0] sq;   // squares fit 15 bits unsigned
  cdp_pkg::sum_vec_t               sum_next;

  // squares
  for (genvar i = 0; i < cdp_pkg::LANES; i++) begin : g_sq
    logic signed [15:0] sq_full;
    assign sq_full = $signed(cvt_data[i]) * $signed(cvt_data[i]);
    assign sq[i]   = sq_full[14:0];  // never negative
  end

  ////////////////////////////////////////////////////////////
  // window around lane c
  ////////////////////////////////////////////////////////////
  for (genvar c = 0; c < cdp_pkg::LANES; c++) begin : g_win
    always_comb begin
      int r;
      r = int'(normalz_len) + 1;
      sum_next[c] = '0;
      for (int j = 0; j < cdp_pkg::LANES; j++) begin
        if ((j >= c - r) && (j <= c + r)) begin
          sum_next[c] = sum_next[c] + 18'(sq[j]);
        end
      end
    end
  end

  assign cvt2sum_ready = ~sum2lut_valid | sum2lut_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      sum2lut_valid <= 1'b0;
    end else if (cvt2sum_ready) begin
      sum2lut_valid <= cvt2sum_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (cvt2sum_valid && cvt2sum_ready) sum2lut_data <= sum_next;
  end

endmodule

`default_nettype wire

/* hdl/cdp_lut.sv */
/*
 * Factor table lookup stage, one output register.
 * Index is sum >> lut_index_select, clamped to LUT_DEPTH-1.
 * Clamped lanes are added to lut_oflow_count on each accepted beat.
 * Table writes are only safe while no beat is in flight.
 * Table contents are undefined until written.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_lut #(
  parameter int LUT_DEPTH = 64
) (
  input  wire logic                         nvdla_core_clk,
  input  wire logic                         nvdla_core_rstn,
  input  wire logic [4:0]                   lut_index_select,
  input  wire logic                         sum2lut_valid,
  output logic                              sum2lut_ready,
  input  wire cdp_pkg::sum_vec_t            sum2lut_data,
  output logic                              lut2mul_valid,
  input  wire logic                         lut2mul_ready,
  output cdp_pkg::fac_vec_t                 lut2mul_data,
  input  wire logic                         lut_wr_en,
  input  wire logic [$clog2(LUT_DEPTH)-1:0] lut_addr,
  input  wire logic [15:0]                  lut_wdata,
  output logic [15:0]                       lut_rd_data,
  output logic [31:0]                       lut_oflow_count
);

  localparam int addr_w = $clog2(LUT_DEPTH);
  localparam int cnt_w  = $clog2(cdp_pkg::LANES + 1);

  logic [15:0]               mem [LUT_DEPTH];
  logic [cdp_pkg::LANES-1:0] clamp;      // lane index past the end
  logic [cnt_w-1:0]          n_clamp;
  cdp_pkg::fac_vec_t         fac_next;
  logic                      accept;

  ////////////////////////////////////////////////////////////
  // index and read, one port per lane
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < cdp_pkg::LANES; i++) begin : g_lane
    logic [17:0]       shifted;
    logic [addr_w-1:0] idx;

    assign shifted     = sum2lut_data[i] >> lut_index_select;
    assign clamp[i]    = shifted > 18'(LUT_DEPTH - 1);
    assign idx         = clamp[i] ? addr_w'(LUT_DEPTH - 1) : shifted[addr_w-1:0];
    assign fac_next[i] = mem[idx];
  end

  always_comb begin
    n_clamp = '0;
    for (int i = 0; i < cdp_pkg::LANES; i++) n_clamp = n_clamp + cnt_w'(clamp[i]);
  end

  assign sum2lut_ready = ~lut2mul_valid | lut2mul_ready;
  assign accept        = sum2lut_valid & sum2lut_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      lut2mul_valid   <= 1'b0;
      lut_oflow_count <= '0;
    end else begin
      if (sum2lut_ready) lut2mul_valid <= sum2lut_valid;
      if (accept) lut_oflow_count <= lut_oflow_count + 32'(n_clamp);  // wraps
    end
  end

  // table write, readback and factor register
  always_ff @(posedge nvdla_core_clk) begin
    if (lut_wr_en) begin
      mem[lut_addr] <= lut_wdata;
    end
    lut_rd_data <= mem[lut_addr];  // one cycle behind lut_addr
    if (accept) begin
      lut2mul_data <= fac_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/cdp_sync_fifo.sv */
/*
 * Holds converted beats until the matching factors arrive.
 * Circular buffer, output valid one cycle after the push.
 * SYNC_DEPTH of 4 or more, the sum path holds fewer beats than that,
 * so the FIFO never fills in normal use.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_sync_fifo #(
  parameter int SYNC_DEPTH = 4
) (
  input  wire logic               nvdla_core_clk,
  input  wire logic               nvdla_core_rstn,
  input  wire logic               cvt2sync_valid,
  output logic                    cvt2sync_ready,
  input  wire cdp_pkg::lane_vec_t cvt_data,
  output logic                    sync2mul_valid,
  input  wire logic               sync2mul_ready,
  output cdp_pkg::lane_vec_t      sync2mul_data
);

  localparam int ptr_w = $clog2(SYNC_DEPTH);
  localparam int cnt_w = $clog2(SYNC_DEPTH + 1);

  cdp_pkg::lane_vec_t mem [SYNC_DEPTH];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;   // occupancy
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  // wrap also for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(SYNC_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full           = count == cnt_w'(SYNC_DEPTH);
  assign empty          = count == '0;
  assign cvt2sync_ready = ~full;
  assign sync2mul_valid = ~empty;
  assign sync2mul_data  = mem[rd_ptr];
  assign push           = cvt2sync_valid & cvt2sync_ready;
  assign pop            = sync2mul_valid & sync2mul_ready;

  ////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (push) mem[wr_ptr] <= cvt_data;
  end

  // beats ahead on the sum path bound the occupancy
  a_no_push_full: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cvt2sync_valid |-> !full);
  // the join only pops when a factor and a beat are both waiting
  a_no_pop_empty: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    sync2mul_ready |-> !empty);

endmodule

`default_nettype wire

/* hdl/cdp_mul_out.sv */
/*
 * Join of converted beat and factors, multiply, shift and saturate.
 * Takes one item from each input in the same cycle, and only when
 * both are valid and the output register is free.
 * With mul_bypass set the converted value passes unchanged.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_mul_out (
  input  wire logic               nvdla_core_clk,
  input  wire logic               nvdla_core_rstn,
  input  wire logic               mul_bypass,
  input  wire logic [5:0]         datout_shifter,
  input  wire logic               sync2mul_valid,
  output logic                    sync2mul_ready,
  input  wire cdp_pkg::lane_vec_t sync2mul_data,
  input  wire logic               lut2mul_valid,
  output logic                    lut2mul_ready,
  input  wire cdp_pkg::fac_vec_t  lut2mul_data,
  output logic                    out_valid,
  input  wire logic               out_ready,
  output cdp_pkg::lane_vec_t      out_data
);

  logic               take;      // join fires
  logic               reg_free;
  cdp_pkg::lane_vec_t res;

  ////////////////////////////////////////////////////////////
  // per lane multiply
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < cdp_pkg::LANES; i++) begin : g_lane
    logic signed [16:0] fac_s;   // factor is unsigned
    logic signed [24:0] prod;
    logic signed [39:0] shf;

    assign fac_s  = {1'b0, lut2mul_data[i]};
    assign prod   = $signed(sync2mul_data[i]) * fac_s;
    assign shf    = prod >>> datout_shifter;  // large shifts give 0 or -1
    assign res[i] = mul_bypass ? sync2mul_data[i] : cdp_pkg::sat_s8(shf);
  end

  assign reg_free       = ~out_valid | out_ready;
  assign take           = sync2mul_valid & lut2mul_valid & reg_free;
  assign sync2mul_ready = take;  // both sides popped together
  assign lut2mul_ready  = take;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;   // taken, nothing new
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (take) begin
      out_data <= res;
    end
  end

endmodule

`default_nettype wire

/* hdl/cdp_dp.sv */
/*
 * Top of the normalization datapath, instances and wires only.
 * Latency 4 cycles from input transfer to out_valid, one beat per cycle.
 * cfg stable while beats are in flight, table writes only when idle.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_dp #(
  parameter int LUT_DEPTH  = 64,
  parameter int SYNC_DEPTH = 4    // at least 4
) (
  input  wire logic                         nvdla_core_clk,
  input  wire logic                         nvdla_core_rstn,
  input  wire cdp_pkg::cfg_t                cfg,
  input  wire logic                         in_valid,
  output logic                              in_ready,
  input  wire cdp_pkg::lane_vec_t           in_data,
  output logic                              out_valid,
  input  wire logic                         out_ready,
  output cdp_pkg::lane_vec_t                out_data,
  input  wire logic                         lut_wr_en,
  input  wire logic [$clog2(LUT_DEPTH)-1:0] lut_addr,
  input  wire logic [15:0]                  lut_wdata,
  output logic [15:0]                       lut_rd_data,
  output logic [31:0]                       lut_oflow_count
);

  logic               cvt2sum_valid, cvt2sum_ready;
  logic               cvt2sync_valid, cvt2sync_ready;
  cdp_pkg::lane_vec_t cvt_data;          // shared by both fork sides
  logic               sum2lut_valid, sum2lut_ready;
  cdp_pkg::sum_vec_t  sum2lut_data;
  logic               lut2mul_valid, lut2mul_ready;
  cdp_pkg::fac_vec_t  lut2mul_data;
  logic               sync2mul_valid, sync2mul_ready;
  cdp_pkg::lane_vec_t sync2mul_data;

  ////////////////////////////////////////////////////////////
  // main path cvt -> sqsum -> lut -> mul
  ////////////////////////////////////////////////////////////
  cdp_cvt_in u_cvt_in (
    .nvdla_core_clk, .nvdla_core_rstn, .cfg,
    .in_valid, .in_ready, .in_data,
    .cvt2sum_valid, .cvt2sum_ready,
    .cvt2sync_valid, .cvt2sync_ready,
    .cvt_data
  );

  cdp_sqsum u_sqsum (
    .nvdla_core_clk, .nvdla_core_rstn,
    .normalz_len   (cfg.normalz_len),
    .cvt2sum_valid, .cvt2sum_ready, .cvt_data,
    .sum2lut_valid, .sum2lut_ready, .sum2lut_data
  );

  cdp_lut #(.LUT_DEPTH(LUT_DEPTH)) u_lut (
    .nvdla_core_clk, .nvdla_core_rstn,
    .lut_index_select (cfg.lut_index_select),
    .sum2lut_valid, .sum2lut_ready, .sum2lut_data,
    .lut2mul_valid, .lut2mul_ready, .lut2mul_data,
    .lut_wr_en, .lut_addr, .lut_wdata, .lut_rd_data, .lut_oflow_count
  );

  // data side, waits for the factors
  cdp_sync_fifo #(.SYNC_DEPTH(SYNC_DEPTH)) u_sync_fifo (
    .nvdla_core_clk, .nvdla_core_rstn,
    .cvt2sync_valid, .cvt2sync_ready, .cvt_data,
    .sync2mul_valid, .sync2mul_ready, .sync2mul_data
  );

  cdp_mul_out u_mul_out (
    .nvdla_core_clk, .nvdla_core_rstn,
    .mul_bypass     (cfg.mul_bypass),
    .datout_shifter (cfg.datout_shifter),
    .sync2mul_valid, .sync2mul_ready, .sync2mul_data,
    .lut2mul_valid, .lut2mul_ready, .lut2mul_data,
    .out_valid, .out_ready, .out_data
  );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
/*
 * Testbench clock and reset, 8 ns period by default.
 * Reset is low from time 0 and released on a falling edge after RESET_CYCLES rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(PERIOD_NS / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (RESET_CYCLES) @(negedge nvdla_core_clk);  // spans RESET_CYCLES rising edges
    nvdla_core_rstn = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/cdp_dp_tb.sv */
/*
 * Directed tests for the normalization datapath, checked against a reference model.
 * Inputs change on the falling edge, transfers are sampled on the rising edge.
 * The table mirror must be written before any normalization beat is sent.
 */
`timescale 1ns/1ps
`default_nettype none

module cdp_dp_tb;

  localparam int LUT_DEPTH = 64;
  localparam int AW        = $clog2(LUT_DEPTH);
  // beats per test, these set the timeout
  localparam int N_TABLE   = 2 * LUT_DEPTH;   // writes plus readbacks
  localparam int N_BYPASS  = 4 * 16;
  localparam int N_NORM    = 4 * 3 * 12;
  localparam int N_BP      = 64;
  localparam int N_OFLOW   = 16;
  localparam int LIMIT     = 2 * (N_TABLE + N_BYPASS + N_NORM + N_BP + N_OFLOW) + 200;

  logic               nvdla_core_clk;
  logic               nvdla_core_rstn;
  cdp_pkg::cfg_t      cfg;
  logic               in_valid;
  logic               in_ready;
  cdp_pkg::lane_vec_t in_data;
  logic               out_valid;
  logic               out_ready;
  cdp_pkg::lane_vec_t out_data;
  logic               lut_wr_en;
  logic [AW-1:0]      lut_addr;
  logic [15:0]        lut_wdata;
  logic [15:0]        lut_rd_data;
  logic [31:0]        lut_oflow_count;

  logic [15:0]        lut_mirror [LUT_DEPTH];  // what the table should hold
  cdp_pkg::lane_vec_t exp_q [$];               // expected output beats
  int                 acc_q [$];               // accept cycle per beat
  logic [31:0]        rng = 32'd17;
  int                 cycle = 0;
  int                 n_acc = 0;
  longint             exp_oflow = 0;
  bit                 check_latency = 1'b0;
  int                 n_err = 0;
  int                 n_checks = 0;
  int                 n_tests = 0;
  int                 n_failed = 0;

  tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) clk_gen_i (
    .nvdla_core_clk, .nvdla_core_rstn
  );

  cdp_dp #(.LUT_DEPTH(LUT_DEPTH), .SYNC_DEPTH(4)) dut_i (
    .nvdla_core_clk, .nvdla_core_rstn, .cfg,
    .in_valid, .in_ready, .in_data,
    .out_valid, .out_ready, .out_data,
    .lut_wr_en, .lut_addr, .lut_wdata, .lut_rd_data, .lut_oflow_count
  );

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic longint clip8(input longint v);
    if (v > 127) return 127;
    if (v < -128) return -128;
    return v;
  endfunction

  // expected output of one beat, plus the number of lanes that clamp the index
  function automatic cdp_pkg::lane_vec_t model_beat(input cdp_pkg::lane_vec_t d,
      input cdp_pkg::cfg_t c, output int n_clamp);
    longint             conv [cdp_pkg::LANES];
    longint             v;
    longint             sum;
    longint             idx;
    int                 r;
    cdp_pkg::lane_vec_t res;
    n_clamp = 0;
    r = int'(c.normalz_len) + 1;  // window radius
    for (int i = 0; i < cdp_pkg::LANES; i++) begin
      v = (longint'($signed(d[i])) - longint'(c.datin_offset)) * longint'(c.datin_scale);
      conv[i] = clip8(v >>> c.datin_shifter);
    end
    for (int i = 0; i < cdp_pkg::LANES; i++) begin
      sum = 0;
      for (int j = i - r; j <= i + r; j++) begin
        if (j >= 0 && j < cdp_pkg::LANES) sum = sum + conv[j] * conv[j];  // outside is zero
      end
      idx = sum >>> c.lut_index_select;
      if (idx > LUT_DEPTH - 1) begin
        idx = LUT_DEPTH - 1;
        n_clamp++;
      end
      if (c.mul_bypass) begin
        v = conv[i];
      end else begin
        v = clip8((conv[i] * longint'(lut_mirror[int'(idx)])) >>> c.datout_shifter);
      end
      res[i] = v[7:0];
    end
    return res;
  endfunction

  function automatic cdp_pkg::cfg_t make_cfg(input int off, input int scl, input int sh,
      input int len, input int sel, input bit byp, input int dsh);
    cdp_pkg::cfg_t c;
    c.datin_offset     = 16'(off);
    c.datin_scale      = 16'(scl);
    c.datin_shifter    = 5'(sh);
    c.normalz_len      = 2'(len);
    c.lut_index_select = 5'(sel);
    c.mul_bypass       = byp;
    c.datout_shifter   = 6'(dsh);
    return c;
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR time %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitor, samples transfers on the rising edge
  ////////////////////////////////////////////////////////////
  always @(posedge nvdla_core_clk) begin : monitor
    int                 nc;
    int                 acc;
    cdp_pkg::lane_vec_t e;
    cycle = cycle + 1;
    if (nvdla_core_rstn) begin
      if (in_valid && in_ready) begin
        e = model_beat(in_data, cfg, nc);  // cfg is stable while beats fly
        exp_q.push_back(e);
        acc_q.push_back(cycle);
        exp_oflow = exp_oflow + nc;
        n_acc++;
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          n_err++;
          $display("unexpected output beat at time %0t with no beat outstanding", $time);
        end else begin
          e   = exp_q.pop_front();
          acc = acc_q.pop_front();
          check_eq(out_data, e, "output beat");
          if (check_latency) check_eq(64'(cycle - acc), 64'd4, "latency in cycles");
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle < LIMIT) @(posedge nvdla_core_clk);
    $display("timeout: run stopped after %0d cycles, the tests did not finish", LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////
  // n random beats back to back, optionally with random out_ready
  task automatic stream(input int n, input bit rand_ready);
    int          base;
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      in_valid = 1'b1;
      in_data  = {rand32(), rand32()};
      base     = n_acc;
      do begin
        @(negedge nvdla_core_clk);
        if (rand_ready) begin
          r = rand32();
          out_ready = r[4];
        end
      end while (n_acc == base);
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    out_ready = 1'b1;
    while (exp_q.size() != 0) @(negedge nvdla_core_clk);
    repeat (2) @(negedge nvdla_core_clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    n_tests++;
    if (n_err == err_before) begin
      $display("test %s: passed", name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", name, n_err - err_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset();
    int e0;
    e0 = n_err;
    check_eq(64'(out_valid), 64'd0, "out_valid after reset");
    check_eq(64'(lut_oflow_count), 64'd0, "overflow count after reset");
    finish_test("reset_state", e0);
  endtask

  task automatic test_table();
    int          e0;
    logic [31:0] r;
    e0 = n_err;
    for (int a = 0; a < LUT_DEPTH; a++) begin
      r = rand32();
      lut_wr_en     = 1'b1;
      lut_addr      = AW'(a);
      lut_wdata     = r[15:0];
      lut_mirror[a] = r[15:0];
      @(negedge nvdla_core_clk);
    end
    lut_wr_en = 1'b0;
    for (int a = 0; a < LUT_DEPTH; a++) begin
      lut_addr = AW'(a);
      @(negedge nvdla_core_clk);  // readback is one cycle behind
      check_eq(64'(lut_rd_data), 64'(lut_mirror[a]), "table readback");
    end
    finish_test("table_programming", e0);
  endtask

  task automatic test_bypass();
    int e0;
    int offs [4] = '{0, -12, 37, 300};
    int scls [4] = '{1, 5, -9, 1000};
    int shfs [4] = '{0, 2, 3, 11};
    e0 = n_err;
    check_latency = 1'b1;
    for (int k = 0; k < 4; k++) begin
      cfg = make_cfg(offs[k], scls[k], shfs[k], 1, 12, 1'b1, 0);
      stream(N_BYPASS / 4, 1'b0);
      drain();
    end
    check_latency = 1'b0;
    finish_test("bypass", e0);
  endtask

  task automatic test_norm();
    int e0;
    int sels [3] = '{9, 11, 13};
    int dshs [3] = '{10, 14, 17};
    e0 = n_err;
    for (int len = 0; len < 4; len++) begin
      for (int k = 0; k < 3; k++) begin
        cfg = make_cfg(3, 2, 1, len, sels[k], 1'b0, dshs[k]);
        stream(N_NORM / 12, 1'b0);
        drain();
      end
    end
    finish_test("normalization", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = n_err;
    cfg = make_cfg(-4, 3, 1, 2, 11, 1'b0, 14);
    stream(N_BP, 1'b1);
    drain();
    check_eq(64'(out_valid), 64'd0, "out_valid after drain");  // no extra beat left
    check_eq(64'(in_ready), 64'd1, "in_ready after drain");
    finish_test("backpressure", e0);
  endtask

  task automatic test_oflow();
    int          e0;
    longint      model_base;
    logic [31:0] dut_base;
    e0 = n_err;
    cfg = make_cfg(0, 1, 0, 3, 0, 1'b0, 8);  // no index shift, wide window
    model_base = exp_oflow;
    dut_base   = lut_oflow_count;
    stream(N_OFLOW, 1'b0);
    drain();
    check_eq(64'(lut_oflow_count - dut_base), 64'(exp_oflow - model_base),
             "overflow count increase");
    check_eq(64'(exp_oflow > model_base), 64'd1, "clamping occurred");
    finish_test("overflow_count", e0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    cfg       = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    lut_wr_en = 1'b0;
    lut_addr  = '0;
    lut_wdata = '0;
    wait (nvdla_core_rstn === 1'b1);
    @(negedge nvdla_core_clk);
    test_reset();
    test_table();
    test_bypass();
    test_norm();
    test_backpressure();
    test_oflow();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_err);
    if (n_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/cdp_pkg.sv
hdl/cdp_cvt_in.sv
hdl/cdp_sqsum.sv
hdl/cdp_lut.sv
hdl/cdp_sync_fifo.sv
hdl/cdp_mul_out.sv
hdl/cdp_dp.sv
tests/tb_clk_gen.sv
tests/cdp_dp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cdp_dp_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
